// File: logic/simt_pkg.sv
// SIMT warp divergence package
// Warp and stack sizes, thread-mask and PC types, and the stack
// entry and split/join request structures

package simt_pkg;

    // Warp and reconvergence stack sizing
    localparam int NUM_THREADS      = 4;
    localparam int STACK_DEPTH      = 4;
    localparam int PC_WIDTH         = 32;
    localparam int STACK_ADDR_WIDTH = $clog2(STACK_DEPTH);

    // One bit per thread of the warp
    typedef logic [NUM_THREADS-1:0] thread_mask_t;

    typedef logic [PC_WIDTH-1:0] pc_t;

    // Slot index or occupied-slot count, wide enough to hold STACK_DEPTH
    typedef logic [$clog2(STACK_DEPTH+1)-1:0] stack_ptr_t;

    // Physical slot address into the stack RAM
    typedef logic [STACK_ADDR_WIDTH-1:0] stack_addr_t;

    // A resume point: which threads run and where they start
    typedef struct packed {
        thread_mask_t mask;
        pc_t          pc;
    } stack_entry_t;

    // One stack slot as stored in RAM
    // The set bit is marked once the else entry has been popped
    typedef struct packed {
        logic         set;
        stack_entry_t q1;
        stack_entry_t q0;
    } stack_word_t;

    typedef struct packed {
        thread_mask_t predicate;
        pc_t          else_pc;
        pc_t          join_pc;
    } split_req_t;

    // Divergence flag returned by the split, handed back at the join
    typedef struct packed {
        logic divergent;
    } join_req_t;

endpackage

// File: logic/ipdom_ram.sv
// Dual-port RAM for the reconvergence stack
// One write port and one registered read port; a write to the
// address being read is forwarded to the read register

module ipdom_ram #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     write,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [DATA_WIDTH-1:0]    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [DATA_WIDTH-1:0]    rdata
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read port
    // Bypass lets the stack see its own update on the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else if (write && (waddr == raddr)) begin
            rdata <= wdata;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: logic/ipdom_stack.sv
// IPDOM reconvergence stack
// Each slot holds a reconvergence entry and an else entry. The first
// pop of a slot returns the else entry and marks the set bit, the
// second pop returns the reconvergence entry and frees the slot

module ipdom_stack (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  logic                  pop,
    input  simt_pkg::stack_entry_t q0,
    input  simt_pkg::stack_entry_t q1,
    output simt_pkg::stack_entry_t d,
    output simt_pkg::stack_ptr_t   depth,
    output logic                  empty,
    output logic                  full
);

    import simt_pkg::*;

    // Number of occupied slots, also the index of the next free slot
    stack_ptr_t  wr_ptr;

    // Slot currently on top, and the one the RAM reads next
    stack_addr_t rd_ptr;
    stack_addr_t rd_ptr_n;

    stack_word_t top;
    stack_word_t wr_word;
    stack_addr_t waddr;

    // Keep the RAM pointed at whatever will be on top after this edge
    always_comb begin
        rd_ptr_n = rd_ptr;
        if (push) begin
            rd_ptr_n = wr_ptr[STACK_ADDR_WIDTH-1:0];
        end else if (pop && top.set) begin
            rd_ptr_n = rd_ptr - stack_addr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + stack_ptr_t'(1);
            end else if (pop && top.set) begin
                // Second pop of the slot frees it
                wr_ptr <= wr_ptr - stack_ptr_t'(1);
            end
            rd_ptr <= rd_ptr_n;
        end
    end

    // A push stores both entries with a clear set bit. A pop rewrites
    // the top slot with the set bit marked
    always_comb begin
        if (push) begin
            wr_word.set = 1'b0;
            wr_word.q1  = q1;
            wr_word.q0  = q0;
            waddr       = wr_ptr[STACK_ADDR_WIDTH-1:0];
        end else begin
            wr_word.set = 1'b1;
            wr_word.q1  = top.q1;
            wr_word.q0  = top.q0;
            waddr       = rd_ptr;
        end
    end

    ipdom_ram #(
        .DATA_WIDTH ($bits(stack_word_t)),
        .DEPTH      (STACK_DEPTH)
    ) store (
        .clk   (clk),
        .reset (reset),
        .write (push || pop),
        .waddr (waddr),
        .wdata (wr_word),
        .raddr (rd_ptr_n),
        .rdata (top)
    );

    // Else entry first, reconvergence entry once the set bit is marked
    assign d     = top.set ? top.q0 : top.q1;
    assign depth = wr_ptr;
    assign empty = (wr_ptr == '0);
    assign full  = (wr_ptr == stack_ptr_t'(STACK_DEPTH));

endmodule

// File: logic/split_join_ctrl.sv
// Split/join controller for one warp
// Owns the active thread mask, decides divergence on a split and
// drives the IPDOM stack, and reports done and redirect one cycle later

module split_join_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   split_valid,
    input  simt_pkg::split_req_t   split_req,
    input  logic                   join_valid,
    input  simt_pkg::join_req_t    join_req,
    input  simt_pkg::stack_entry_t stack_top,
    output logic                   push,
    output logic                   pop,
    output simt_pkg::stack_entry_t push_reconv,
    output simt_pkg::stack_entry_t push_else,
    output simt_pkg::thread_mask_t tmask,
    output logic                   redirect_valid,
    output simt_pkg::pc_t          redirect_pc,
    output logic                   split_done,
    output logic                   split_divergent,
    output logic                   join_done
);

    import simt_pkg::*;

    thread_mask_t tmask_r;
    thread_mask_t taken_mask;
    thread_mask_t else_mask;
    logic         divergent;
    logic         all_not_taken;

    logic         redirect_next;
    pc_t          redirect_pc_next;

    // Split the active threads by the predicate
    assign taken_mask    = tmask_r & split_req.predicate;
    assign else_mask     = tmask_r & ~split_req.predicate;
    assign divergent     = (taken_mask != '0) && (else_mask != '0);
    assign all_not_taken = (taken_mask == '0);

    // Stack requests are issued in the request cycle itself
    assign push = split_valid && divergent;
    assign pop  = join_valid && join_req.divergent;

    // Reconvergence entry restores the full mask at the join point
    assign push_reconv.mask = tmask_r;
    assign push_reconv.pc   = split_req.join_pc;

    // Else entry resumes the not-taken threads
    assign push_else.mask = else_mask;
    assign push_else.pc   = split_req.else_pc;

    // A uniform not-taken split jumps straight to the else path.
    // A divergent join resumes at whatever the stack hands back
    always_comb begin
        redirect_next    = 1'b0;
        redirect_pc_next = stack_top.pc;
        if (split_valid && all_not_taken) begin
            redirect_next    = 1'b1;
            redirect_pc_next = split_req.else_pc;
        end else if (pop) begin
            redirect_next    = 1'b1;
            redirect_pc_next = stack_top.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tmask_r <= '1;
        end else if (push) begin
            tmask_r <= taken_mask;
        end else if (pop) begin
            tmask_r <= stack_top.mask;
        end
    end

    // Response strobes, one cycle after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid  <= 1'b0;
            split_done      <= 1'b0;
            split_divergent <= 1'b0;
            join_done       <= 1'b0;
        end else begin
            redirect_valid  <= redirect_next;
            split_done      <= split_valid;
            split_divergent <= push;
            join_done       <= join_valid;
        end
    end

    // Only meaningful while redirect_valid is high
    always_ff @(posedge clk) begin
        if (redirect_next) begin
            redirect_pc <= redirect_pc_next;
        end
    end

    assign tmask = tmask_r;

endmodule

// File: logic/warp_mask_unit.sv
// Warp divergence unit
// Joins the split/join controller to its IPDOM reconvergence stack

module warp_mask_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   split_valid,
    input  simt_pkg::split_req_t   split_req,
    input  logic                   join_valid,
    input  simt_pkg::join_req_t    join_req,
    output simt_pkg::thread_mask_t tmask,
    output logic                   redirect_valid,
    output simt_pkg::pc_t          redirect_pc,
    output logic                   split_done,
    output logic                   split_divergent,
    output logic                   join_done,
    output logic                   empty,
    output logic                   full,
    output simt_pkg::stack_ptr_t   depth
);

    import simt_pkg::*;

    logic         push;
    logic         pop;
    stack_entry_t push_reconv;
    stack_entry_t push_else;
    stack_entry_t stack_top;

    split_join_ctrl ctrl (
        .clk             (clk),
        .reset           (reset),
        .split_valid     (split_valid),
        .split_req       (split_req),
        .join_valid      (join_valid),
        .join_req        (join_req),
        .stack_top       (stack_top),
        .push            (push),
        .pop             (pop),
        .push_reconv     (push_reconv),
        .push_else       (push_else),
        .tmask           (tmask),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .split_done      (split_done),
        .split_divergent (split_divergent),
        .join_done       (join_done)
    );

    // q0 holds the reconvergence entry, q1 the else entry
    ipdom_stack stack (
        .clk   (clk),
        .reset (reset),
        .push  (push),
        .pop   (pop),
        .q0    (push_reconv),
        .q1    (push_else),
        .d     (stack_top),
        .depth (depth),
        .empty (empty),
        .full  (full)
    );

endmodule

// File: verif/tb_warp_mask_unit.sv
// Testbench for the warp divergence unit
// Directed split/join sequences against a reference model of the
// IPDOM stack and the active thread mask, plus random back-to-back traffic

module tb_warp_mask_unit;

    import simt_pkg::*;

    // The tests take about 600 cycles
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RANDOM_OPS     = 450;

    logic         clk;
    logic         reset;
    logic         split_valid;
    split_req_t   split_req;
    logic         join_valid;
    join_req_t    join_req;
    thread_mask_t tmask;
    logic         redirect_valid;
    pc_t          redirect_pc;
    logic         split_done;
    logic         split_divergent;
    logic         join_done;
    logic         empty;
    logic         full;
    stack_ptr_t   depth;

    // Reference model: one word per occupied slot, top at the back
    stack_word_t  slot_model[$];
    thread_mask_t model_tmask;

    int error_count;
    int checks_done;
    int tests_run;
    int tests_failed;
    int cycle_count;

    warp_mask_unit UUT (
        .clk             (clk),
        .reset           (reset),
        .split_valid     (split_valid),
        .split_req       (split_req),
        .join_valid      (join_valid),
        .join_req        (join_req),
        .tmask           (tmask),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .split_done      (split_done),
        .split_divergent (split_divergent),
        .join_done       (join_done),
        .empty           (empty),
        .full            (full),
        .depth           (depth)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks_done++;
        assert (got === exp) else begin
            $display("CHECK FAILED at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            error_count++;
        end
    endtask

    // Drives one request on the falling edge, advances the model by the
    // split and join rules and checks the response one cycle later
    task automatic apply_request(input logic is_split, input logic is_join,
                                 input split_req_t sreq, input join_req_t jreq);
        thread_mask_t taken;
        thread_mask_t not_taken;
        stack_word_t  slot;
        logic         exp_divergent;
        logic         exp_redirect;
        pc_t          exp_pc;

        exp_divergent = 1'b0;
        exp_redirect  = 1'b0;
        exp_pc        = '0;
        split_valid   = is_split;
        split_req     = sreq;
        join_valid    = is_join;
        join_req      = jreq;

        if (is_split) begin
            taken     = model_tmask & sreq.predicate;
            not_taken = model_tmask & ~sreq.predicate;
            if ((taken != '0) && (not_taken != '0)) begin
                slot.set     = 1'b0;
                slot.q0.mask = model_tmask;
                slot.q0.pc   = sreq.join_pc;
                slot.q1.mask = not_taken;
                slot.q1.pc   = sreq.else_pc;
                slot_model.push_back(slot);
                model_tmask   = taken;
                exp_divergent = 1'b1;
            end else if (taken == '0) begin
                exp_redirect = 1'b1;
                exp_pc       = sreq.else_pc;
            end
        end else if (is_join && jreq.divergent) begin
            if (slot_model.size() == 0) begin
                $display("Test sequence error: divergent join issued on an empty stack");
                error_count++;
            end else begin
                slot         = slot_model[slot_model.size()-1];
                exp_redirect = 1'b1;
                if (!slot.set) begin
                    // First pop resumes the else path and keeps the slot
                    model_tmask = slot.q1.mask;
                    exp_pc      = slot.q1.pc;
                    slot.set    = 1'b1;
                    slot_model[slot_model.size()-1] = slot;
                end else begin
                    model_tmask = slot.q0.mask;
                    exp_pc      = slot.q0.pc;
                    void'(slot_model.pop_back());
                end
            end
        end

        @(negedge clk);
        split_valid = 1'b0;
        join_valid  = 1'b0;

        expect_equal("tmask", tmask, model_tmask);
        expect_equal("depth", depth, slot_model.size());
        expect_equal("empty", empty, slot_model.size() == 0);
        expect_equal("full", full, slot_model.size() == STACK_DEPTH);
        expect_equal("split_done", split_done, is_split);
        expect_equal("split_divergent", split_divergent, exp_divergent);
        expect_equal("join_done", join_done, is_join);
        expect_equal("redirect_valid", redirect_valid, exp_redirect);
        if (exp_redirect) begin
            expect_equal("redirect_pc", redirect_pc, exp_pc);
        end
    endtask

    task automatic issue_split(input thread_mask_t predicate, input pc_t else_pc,
                               input pc_t join_pc);
        split_req_t req;

        req.predicate = predicate;
        req.else_pc   = else_pc;
        req.join_pc   = join_pc;
        apply_request(1'b1, 1'b0, req, '0);
    endtask

    task automatic issue_join(input logic divergent);
        join_req_t req;

        req.divergent = divergent;
        apply_request(1'b0, 1'b1, '0, req);
    endtask

    task automatic idle_cycle();
        apply_request(1'b0, 1'b0, '0, '0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%-28s passed", name);
        end else begin
            tests_failed++;
            $display("%-28s FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic after_reset();
        int errors_before;

        errors_before = error_count;
        expect_equal("tmask after reset", tmask, 4'b1111);
        expect_equal("empty after reset", empty, 1'b1);
        expect_equal("full after reset", full, 1'b0);
        expect_equal("depth after reset", depth, 0);
        expect_equal("redirect_valid after reset", redirect_valid, 1'b0);
        expect_equal("split_done after reset", split_done, 1'b0);
        expect_equal("join_done after reset", join_done, 1'b0);
        repeat (4) idle_cycle();
        report_test("after reset", errors_before);
    endtask

    task automatic uniform_splits();
        int errors_before;

        errors_before = error_count;
        // All active threads taken, then none taken
        issue_split(4'b1111, 32'h0000_0100, 32'h0000_0200);
        issue_split(4'b0000, 32'h0000_0340, 32'h0000_0400);
        idle_cycle();
        report_test("uniform splits", errors_before);
    endtask

    task automatic if_else_reconverge();
        int errors_before;

        errors_before = error_count;
        issue_split(4'b0101, 32'h0000_1000, 32'h0000_2000);
        issue_join(1'b1);
        issue_join(1'b1);
        expect_equal("empty after reconvergence", empty, 1'b1);
        idle_cycle();
        report_test("if/else reconvergence", errors_before);
    endtask

    // Four threads allow at most three nested divergent splits, since each
    // level drops at least one thread from the active mask
    task automatic nested_divergence();
        int errors_before;

        errors_before = error_count;
        issue_split(4'b0111, 32'h0000_3000, 32'h0000_3800);
        issue_split(4'b0011, 32'h0000_3100, 32'h0000_3700);
        issue_split(4'b0001, 32'h0000_3200, 32'h0000_3600);
        issue_join(1'b1);
        issue_join(1'b1);
        // The freed top slot is taken again by a second split on the same path
        issue_split(4'b1010, 32'h0000_4000, 32'h0000_4100);
        while (slot_model.size() > 0) begin
            issue_join(1'b1);
        end
        expect_equal("tmask after unwind", tmask, 4'b1111);
        report_test("nested divergence", errors_before);
    endtask

    task automatic plain_join();
        int errors_before;

        errors_before = error_count;
        issue_join(1'b0);
        issue_split(4'b0110, 32'h0000_5000, 32'h0000_5100);
        issue_join(1'b0);
        issue_join(1'b1);
        issue_join(1'b0);
        issue_join(1'b1);
        idle_cycle();
        report_test("join without divergence", errors_before);
    endtask

    task automatic random_traffic();
        int          errors_before;
        int unsigned op;
        pc_t         else_pc;
        pc_t         join_pc;

        errors_before = error_count;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            op      = $urandom_range(0, 9);
            else_pc = $urandom & 32'hFFFF_FFFC;
            join_pc = $urandom & 32'hFFFF_FFFC;
            if (op < 5 && slot_model.size() < STACK_DEPTH) begin
                issue_split(thread_mask_t'($urandom), else_pc, join_pc);
            end else if (op < 8 && slot_model.size() > 0) begin
                issue_join(1'b1);
            end else if (op < 8) begin
                issue_split(thread_mask_t'($urandom), else_pc, join_pc);
            end else if (op == 8) begin
                issue_join(1'b0);
            end else begin
                idle_cycle();
            end
        end
        while (slot_model.size() > 0) begin
            issue_join(1'b1);
        end
        idle_cycle();
        report_test("random back-to-back traffic", errors_before);
    endtask

    initial begin
        void'($urandom(24648));
        error_count  = 0;
        checks_done  = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        split_valid  = 1'b0;
        split_req    = '0;
        join_valid   = 1'b0;
        join_req     = '0;
        model_tmask  = '1;
        slot_model.delete();

        repeat (8) @(negedge clk);
        reset = 1'b0;

        after_reset();
        uniform_splits();
        if_else_reconverge();
        nested_divergence();
        plain_join();
        random_traffic();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks_done, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/simt_pkg.sv
logic/ipdom_ram.sv
logic/ipdom_stack.sv
logic/split_join_ctrl.sv
logic/warp_mask_unit.sv
verif/tb_warp_mask_unit.sv

// File: Bender.yml
package:
  name: warp_mask_unit

dependencies: {}

sources:
  # Package first, then the RAM, the stack, the controller and the top level
  - files:
      - logic/simt_pkg.sv
      - logic/ipdom_ram.sv
      - logic/ipdom_stack.sv
      - logic/split_join_ctrl.sv
      - logic/warp_mask_unit.sv

  # Directed testbench for the warp divergence unit
  - target: test
    files:
      - verif/tb_warp_mask_unit.sv
